// File: csr_block.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module csr_block (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_pkg::wb_m2s_t         bus_m2s,
    output wb_pkg::wb_s2m_t         bus_s2m,
    output logic                    start,
    output logic [`SSSP_ADDR_W-1:0] start_addr,
    input  logic                    job_done,
    input  logic [`SSSP_DATA_W-1:0] update_total
);
    import sssp_pkg::*;

    localparam int REG_CTRL  = 0;
    localparam int REG_TOTAL = 1;

    csr_status_t             status;
    logic                    ack;
    logic [`SSSP_DATA_W-1:0] rdata;
    logic                    access;
    logic                    accept_start;

    // The ack blocks a second access, which gives the wait cycle between bus cycles
    assign access       = bus_m2s.cyc && bus_m2s.stb && !ack;
    assign accept_start = access && bus_m2s.we && (bus_m2s.adr == REG_CTRL) && !status.busy;

    assign bus_s2m = '{ack: ack, dat: rdata};

    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            start  <= 1'b0;
            status <= '0;
        end else begin
            ack   <= access;
            start <= accept_start;
            if (accept_start) begin
                status.busy <= 1'b1;
                status.done <= 1'b0;
            end else if (job_done) begin
                status.busy <= 1'b0;
                status.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_start) begin
            start_addr <= bus_m2s.dat;
        end
        if (access) begin
            case (bus_m2s.adr)
                REG_CTRL:  rdata <= `SSSP_DATA_W'(status);
                REG_TOTAL: rdata <= update_total;
                default:   rdata <= '0;
            endcase
        end
    end

endmodule

// File: desc_sequencer.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module desc_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [`SSSP_ADDR_W-1:0]  start_addr,
    output wb_pkg::mem_req_t         mem_req,
    input  wb_pkg::mem_rsp_t         mem_rsp,
    output logic                     vwr_valid,
    output logic [`SSSP_VIDX_W-1:0]  vwr_idx,
    output logic [`SSSP_LEVEL_W-1:0] vwr_level,
    output logic                     lookup_valid,
    output sssp_pkg::edge_t          lookup_edge,
    output logic [`SSSP_LEVEL_W-1:0] level,
    input  logic                     hit,
    input  sssp_pkg::update_t        update,
    output logic                     job_done,
    output logic [`SSSP_DATA_W-1:0]  update_total
);
    import sssp_pkg::*;

    localparam logic [1:0] EDGE_READ   = 2'd0;
    localparam logic [1:0] EDGE_LOOKUP = 2'd1;
    localparam logic [1:0] EDGE_RESULT = 2'd2;
    localparam logic [1:0] EDGE_WRITE  = 2'd3;

    seq_state_t              state;
    desc_t                   desc;
    logic [`SSSP_ADDR_W-1:0] desc_addr;
    logic [`SSSP_DATA_W-1:0] item_cnt;
    logic [`SSSP_DATA_W-1:0] upd_cnt;
    logic [1:0]              edge_phase;
    logic                    req_valid;
    logic                    req_write;
    logic [`SSSP_ADDR_W-1:0] req_addr;
    logic [`SSSP_DATA_W-1:0] req_data;

    assign mem_req = '{valid: req_valid, write: req_write, addr: req_addr, data: req_data};
    assign level   = desc.level;

    ////////////////////////////////////////////////////////////////////////////
    // Main FSM, one memory word in flight at a time
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IDLE;
            req_valid    <= 1'b0;
            vwr_valid    <= 1'b0;
            lookup_valid <= 1'b0;
            job_done     <= 1'b0;
            update_total <= '0;
            item_cnt     <= '0;
            upd_cnt      <= '0;
            edge_phase   <= EDGE_READ;
        end else begin
            vwr_valid    <= 1'b0;
            lookup_valid <= 1'b0;
            job_done     <= 1'b0;
            if (mem_rsp.done) begin
                req_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        desc_addr    <= start_addr;
                        item_cnt     <= '0;
                        update_total <= '0;
                        state        <= ST_READ_DESC;
                    end
                end
                ST_READ_DESC: begin
                    if (mem_rsp.done) begin
                        desc <= desc_t'({desc[$bits(desc_t)-`SSSP_DATA_W-1:0], mem_rsp.data});
                        if (item_cnt == `SSSP_DESC_WORDS - 1) begin
                            state <= ST_CONFIG;
                        end else begin
                            item_cnt <= item_cnt + 1'b1;
                        end
                    end else if (!req_valid) begin
                        req_valid <= 1'b1;
                        req_write <= 1'b0;
                        req_addr  <= desc_addr + item_cnt;
                    end
                end
                ST_CONFIG: begin
                    item_cnt <= '0;
                    upd_cnt  <= '0;
                    state    <= ST_READ_VERTEX;
                end
                ST_READ_VERTEX: begin
                    if (mem_rsp.done) begin
                        vwr_valid <= 1'b1;
                        vwr_idx   <= item_cnt[`SSSP_VIDX_W-1:0];
                        vwr_level <= mem_rsp.data[`SSSP_LEVEL_W-1:0];
                        item_cnt  <= item_cnt + 1'b1;
                    end else if (!req_valid) begin
                        if (item_cnt == desc.vertex_count) begin
                            item_cnt   <= '0;
                            edge_phase <= EDGE_READ;
                            state      <= ST_PROCESS_EDGE;
                        end else begin
                            req_valid <= 1'b1;
                            req_write <= 1'b0;
                            req_addr  <= desc.vertex_addr + item_cnt;
                        end
                    end
                end
                ST_PROCESS_EDGE: begin
                    case (edge_phase)
                        EDGE_READ: begin
                            if (mem_rsp.done) begin
                                lookup_valid <= 1'b1;
                                lookup_edge  <= edge_t'(mem_rsp.data);
                                edge_phase   <= EDGE_LOOKUP;
                            end else if (!req_valid) begin
                                if (item_cnt == desc.edge_count) begin
                                    state <= ST_WRITE_STATUS;
                                end else begin
                                    req_valid <= 1'b1;
                                    req_write <= 1'b0;
                                    req_addr  <= desc.edge_addr + item_cnt;
                                end
                            end
                        end
                        // Filter result shows up one cycle after the lookup
                        EDGE_LOOKUP: begin
                            edge_phase <= EDGE_RESULT;
                        end
                        EDGE_RESULT: begin
                            item_cnt <= item_cnt + 1'b1;
                            if (hit) begin
                                req_valid  <= 1'b1;
                                req_write  <= 1'b1;
                                req_addr   <= desc.update_addr + upd_cnt;
                                req_data   <= update;
                                edge_phase <= EDGE_WRITE;
                            end else begin
                                edge_phase <= EDGE_READ;
                            end
                        end
                        EDGE_WRITE: begin
                            if (mem_rsp.done) begin
                                upd_cnt      <= upd_cnt + 1'b1;
                                update_total <= update_total + 1'b1;
                                edge_phase   <= EDGE_READ;
                            end
                        end
                    endcase
                end
                ST_WRITE_STATUS: begin
                    if (mem_rsp.done) begin
                        if (desc.next_addr != '0) begin
                            desc_addr <= desc.next_addr;
                            item_cnt  <= '0;
                            state     <= ST_READ_DESC;
                        end else begin
                            state <= ST_FINISH;
                        end
                    end else if (!req_valid) begin
                        req_valid <= 1'b1;
                        req_write <= 1'b1;
                        req_addr  <= desc.status_addr;
                        req_data  <= upd_cnt;
                    end
                end
                ST_FINISH: begin
                    job_done <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: frontier_filter.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module frontier_filter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     vwr_valid,
    input  logic [`SSSP_VIDX_W-1:0]  vwr_idx,
    input  logic [`SSSP_LEVEL_W-1:0] vwr_level,
    input  logic                     lookup_valid,
    input  sssp_pkg::edge_t          lookup_edge,
    input  logic [`SSSP_LEVEL_W-1:0] level,
    output logic                     hit,
    output sssp_pkg::update_t        update
);

    logic [`SSSP_LEVEL_W-1:0] level_mem [`SSSP_VERTEX_DEPTH];
    logic                     src_in_frontier;
    logic                     dst_unvisited;

    assign src_in_frontier = (level_mem[lookup_edge.src] == level);
    assign dst_unvisited   = (level_mem[lookup_edge.dst] == `SSSP_UNVISITED);

    // Only the vertex load writes the store, hits leave it untouched
    always_ff @(posedge clk) begin
        if (vwr_valid) begin
            level_mem[vwr_idx] <= vwr_level;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup_valid && src_in_frontier && dst_unvisited;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            update.level <= level + 1'b1;
            update.rsvd  <= '0;
            update.dst   <= lookup_edge.dst;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sssp_accel.f \
    --top-module tb_sssp_accel \
    -o sim_sssp_accel

./obj_dir/sim_sssp_accel

// File: sssp_accel.f
+incdir+.
wb_pkg.sv
sssp_pkg.sv
csr_block.sv
wb_master_port.sv
frontier_filter.sv
desc_sequencer.sv
sssp_accel_top.sv
tb_sssp_accel.sv

// File: sssp_accel_top.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module sssp_accel_top (
    input  logic            clk,
    input  logic            reset,
    input  wb_pkg::wb_m2s_t csr_m2s,
    output wb_pkg::wb_s2m_t csr_s2m,
    output wb_pkg::wb_m2s_t mem_m2s,
    input  wb_pkg::wb_s2m_t mem_s2m
);
    import wb_pkg::*;
    import sssp_pkg::*;

    logic                     start;
    logic [`SSSP_ADDR_W-1:0]  start_addr;
    logic                     job_done;
    logic [`SSSP_DATA_W-1:0]  update_total;
    mem_req_t                 mem_req;
    mem_rsp_t                 mem_rsp;
    logic                     vwr_valid;
    logic [`SSSP_VIDX_W-1:0]  vwr_idx;
    logic [`SSSP_LEVEL_W-1:0] vwr_level;
    logic                     lookup_valid;
    edge_t                    lookup_edge;
    logic [`SSSP_LEVEL_W-1:0] level;
    logic                     hit;
    update_t                  update;

    csr_block i_csr_block (
        .clk          (clk),
        .reset        (reset),
        .bus_m2s      (csr_m2s),
        .bus_s2m      (csr_s2m),
        .start        (start),
        .start_addr   (start_addr),
        .job_done     (job_done),
        .update_total (update_total)
    );

    desc_sequencer i_desc_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .start_addr   (start_addr),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .vwr_valid    (vwr_valid),
        .vwr_idx      (vwr_idx),
        .vwr_level    (vwr_level),
        .lookup_valid (lookup_valid),
        .lookup_edge  (lookup_edge),
        .level        (level),
        .hit          (hit),
        .update       (update),
        .job_done     (job_done),
        .update_total (update_total)
    );

    frontier_filter i_frontier_filter (
        .clk          (clk),
        .reset        (reset),
        .vwr_valid    (vwr_valid),
        .vwr_idx      (vwr_idx),
        .vwr_level    (vwr_level),
        .lookup_valid (lookup_valid),
        .lookup_edge  (lookup_edge),
        .level        (level),
        .hit          (hit),
        .update       (update)
    );

    wb_master_port i_wb_master_port (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .rsp     (mem_rsp),
        .bus_m2s (mem_m2s),
        .bus_s2m (mem_s2m)
    );

endmodule

// File: sssp_macros.svh
`ifndef SSSP_MACROS_SVH
`define SSSP_MACROS_SVH

// Memory words and addresses, all addresses count words
`define SSSP_ADDR_W 32
`define SSSP_DATA_W 32

// Vertex indexing and the local level store
`define SSSP_VIDX_W 8
`define SSSP_VERTEX_DEPTH 256
`define SSSP_LEVEL_W 16

// Descriptor length in words
`define SSSP_DESC_WORDS 8

// Level value of a vertex that no frontier has reached yet
`define SSSP_UNVISITED 16'hffff

`endif

// File: sssp_pkg.sv
`include "sssp_macros.svh"

package sssp_pkg;

    // Words arrive in this order, so the first word read lands in the top field
    typedef struct packed {
        logic [`SSSP_ADDR_W-1:0]                next_addr;
        logic [`SSSP_ADDR_W-1:0]                vertex_addr;
        logic [`SSSP_DATA_W-1:0]                vertex_count;
        logic [`SSSP_ADDR_W-1:0]                edge_addr;
        logic [`SSSP_DATA_W-1:0]                edge_count;
        logic [`SSSP_ADDR_W-1:0]                update_addr;
        logic [`SSSP_ADDR_W-1:0]                status_addr;
        logic [`SSSP_DATA_W-`SSSP_LEVEL_W-1:0] rsvd;
        logic [`SSSP_LEVEL_W-1:0]               level;
    } desc_t;

    typedef struct packed {
        logic [7:0]               rsvd_hi;
        logic [`SSSP_VIDX_W-1:0] src;
        logic [7:0]               rsvd_lo;
        logic [`SSSP_VIDX_W-1:0] dst;
    } edge_t;

    typedef struct packed {
        logic [`SSSP_LEVEL_W-1:0]                              level;
        logic [`SSSP_DATA_W-`SSSP_LEVEL_W-`SSSP_VIDX_W-1:0] rsvd;
        logic [`SSSP_VIDX_W-1:0]                              dst;
    } update_t;

    // Busy sits in bit 0 of register 0, done in bit 1
    typedef struct packed {
        logic done;
        logic busy;
    } csr_status_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_DESC,
        ST_CONFIG,
        ST_READ_VERTEX,
        ST_PROCESS_EDGE,
        ST_WRITE_STATUS,
        ST_FINISH
    } seq_state_t;

endpackage

// File: tb_sssp_accel.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module tb_sssp_accel;
    import wb_pkg::*;
    import sssp_pkg::*;

    localparam int MEM_WORDS   = 4096;
    localparam int REGION_SIZE = 512;
    localparam int STATUS_OFS  = 8;
    localparam int VERTEX_OFS  = 16;
    localparam int EDGE_OFS    = 80;
    localparam int UPDATE_OFS  = 176;
    localparam int REG_CTRL    = 0;
    localparam int REG_TOTAL   = 1;
    localparam int ACK_TIMEOUT = 32;
    localparam int POLL_LIMIT  = 5000;
    localparam int N_CASES     = 6;

    typedef struct packed {
        int          num_desc;
        int          vertex_count;
        int          edge_count;
        logic [15:0] level;
        logic        restart;
    } case_t;

    // Descriptors, vertex count, edge count, level, second start while busy
    case_t cases [N_CASES] = '{
        '{1, 16, 24, 16'd0,    1'b0},
        '{1, 64, 96, 16'd5,    1'b0},
        '{3, 24, 32, 16'd2,    1'b0},
        '{1, 32, 40, 16'd7,    1'b1},
        '{1, 4,  0,  16'd3,    1'b0},
        '{2, 8,  16, 16'h0100, 1'b0}
    };

    logic        clk;
    logic        reset;
    wb_m2s_t     csr_m2s;
    wb_s2m_t     csr_s2m;
    wb_m2s_t     mem_m2s;
    wb_s2m_t     mem_s2m = '0;
    logic [31:0] mem   [MEM_WORDS];
    logic [31:0] image [MEM_WORDS];
    logic [31:0] lfsr_state = 32'hc01d_24b0;
    logic [1:0]  wait_left = '0;

    sssp_accel_top i_sssp_accel_top (
        .clk     (clk),
        .reset   (reset),
        .csr_m2s (csr_m2s),
        .csr_s2m (csr_s2m),
        .mem_m2s (mem_m2s),
        .mem_s2m (mem_s2m)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [31:0] region_base(input int d);
        return 32'(REGION_SIZE * (d + 1));
    endfunction

    function automatic logic [31:0] sentinel(input logic [31:0] addr);
        return 32'hdead_0000 ^ addr;
    endfunction

    function automatic csr_status_t status_of(input logic busy, input logic done);
        csr_status_t s;
        s.busy = busy;
        s.done = done;
        return s;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_update(input string name, input update_t got, input update_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input csr_status_t got,
                                input csr_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // One Wishbone classic cycle on the register port
    task automatic csr_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        csr_m2s = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!csr_s2m.ack) begin
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run($sformatf("Register access at address %0d got no acknowledge", adr));
            end
            @(negedge clk);
        end
        rdat    = csr_s2m.dat;
        csr_m2s = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory slave with zero to three wait states per cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (mem_s2m.ack) begin
            mem_s2m.ack = 1'b0;
        end else if (mem_m2s.cyc && mem_m2s.stb) begin
            if (mem_m2s.adr >= MEM_WORDS) begin
                abort_run($sformatf("Memory access outside the model at %h", mem_m2s.adr));
            end else if (wait_left != 0) begin
                wait_left = wait_left - 2'd1;
            end else begin
                mem_s2m.ack = 1'b1;
                if (mem_m2s.we) begin
                    mem[mem_m2s.adr] = mem_m2s.dat;
                end else begin
                    mem_s2m.dat = mem[mem_m2s.adr];
                end
                wait_left = 2'(random_bits(2));
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job setup and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_case(input case_t c);
        logic [31:0] base;
        logic [15:0] lvl;
        logic [7:0]  src;
        logic [7:0]  dst;
        int          d;
        int          i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5eed_0000 ^ 32'(i);
        end
        for (d = 0; d < c.num_desc; d++) begin
            base          = region_base(d);
            mem[base]     = (d == c.num_desc - 1) ? '0 : region_base(d + 1);
            mem[base + 1] = base + VERTEX_OFS;
            mem[base + 2] = c.vertex_count;
            mem[base + 3] = base + EDGE_OFS;
            mem[base + 4] = c.edge_count;
            mem[base + 5] = base + UPDATE_OFS;
            mem[base + 6] = base + STATUS_OFS;
            mem[base + 7] = {16'h0000, c.level};
            for (i = 0; i < c.vertex_count; i++) begin
                case (random_bits(2))
                    0:       lvl = c.level;
                    1, 2:    lvl = `SSSP_UNVISITED;
                    default: lvl = c.level + 16'd2;
                endcase
                // Upper half is junk that the level store never sees
                mem[base + VERTEX_OFS + i] = {8'(d), 8'h5c, lvl};
            end
            for (i = 0; i < c.edge_count; i++) begin
                src = 8'(random_bits(8) % c.vertex_count);
                dst = 8'(random_bits(8) % c.vertex_count);
                mem[base + EDGE_OFS + i] = {8'h00, src, 8'h00, dst};
            end
            for (i = 0; i <= c.edge_count; i++) begin
                mem[base + UPDATE_OFS + i] = sentinel(base + UPDATE_OFS + i);
            end
            mem[base + STATUS_OFS] = sentinel(base + STATUS_OFS);
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            image[i] = mem[i];
        end
    endtask

    // An edge yields an update when its source is on the frontier and its destination unvisited
    task automatic check_results(input case_t c, output int total);
        logic [31:0] base;
        logic [31:0] word;
        update_t     exp;
        int          d;
        int          e;
        int          count;
        total = 0;
        for (d = 0; d < c.num_desc; d++) begin
            base  = region_base(d);
            count = 0;
            for (e = 0; e < c.edge_count; e++) begin
                word = image[base + EDGE_OFS + e];
                if (image[base + VERTEX_OFS + word[23:16]][15:0] == c.level &&
                    image[base + VERTEX_OFS + word[7:0]][15:0] == `SSSP_UNVISITED) begin
                    exp.level = c.level + 16'd1;
                    exp.rsvd  = '0;
                    exp.dst   = word[7:0];
                    check_update($sformatf("mem[%h]", base + UPDATE_OFS + count),
                                 update_t'(mem[base + UPDATE_OFS + count]), exp);
                    count++;
                end
            end
            check_count($sformatf("mem[%h]", base + UPDATE_OFS + count),
                        mem[base + UPDATE_OFS + count], sentinel(base + UPDATE_OFS + count));
            check_count($sformatf("mem[%h]", base + STATUS_OFS),
                        mem[base + STATUS_OFS], 32'(count));
            total += count;
        end
    endtask

    task automatic run_case(input case_t c);
        logic [31:0] rd;
        csr_status_t st;
        int          polls;
        int          total;
        build_case(c);
        csr_access(1'b1, REG_CTRL, region_base(0), rd);
        csr_access(1'b0, REG_CTRL, '0, rd);
        check_status("csr_status", csr_status_t'(rd[1:0]), status_of(1'b1, 1'b0));
        // Aimed at an empty region, so taking it would show up in the results
        if (c.restart) begin
            csr_access(1'b1, REG_CTRL, region_base(c.num_desc), rd);
        end
        st    = '0;
        polls = 0;
        while (!st.done) begin
            if (polls == POLL_LIMIT) begin
                abort_run($sformatf("Job did not finish within %0d status polls", POLL_LIMIT));
            end
            csr_access(1'b0, REG_CTRL, '0, rd);
            st = csr_status_t'(rd[1:0]);
            polls++;
        end
        check_status("csr_status", st, status_of(1'b0, 1'b1));
        check_results(c, total);
        csr_access(1'b0, REG_TOTAL, '0, rd);
        check_count("update_total", rd, 32'(total));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        int          n;
        clk     = 1'b0;
        reset   = 1'b1;
        csr_m2s = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        csr_access(1'b0, REG_CTRL, '0, rd);
        check_status("csr_status", csr_status_t'(rd[1:0]), status_of(1'b0, 1'b0));
        csr_access(1'b0, REG_TOTAL, '0, rd);
        check_count("update_total", rd, '0);
        for (n = 0; n < N_CASES; n++) begin
            run_case(cases[n]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: wb_master_port.sv
`timescale 1ns/1ns
`include "sssp_macros.svh"

module wb_master_port (
    input  logic             clk,
    input  logic             reset,
    input  wb_pkg::mem_req_t req,
    output wb_pkg::mem_rsp_t rsp,
    output wb_pkg::wb_m2s_t  bus_m2s,
    input  wb_pkg::wb_s2m_t  bus_s2m
);

    typedef enum logic {
        PORT_IDLE,
        PORT_CYCLE
    } port_state_t;

    port_state_t             state;
    logic                    done;
    logic                    launch;
    logic                    we;
    logic [`SSSP_ADDR_W-1:0] adr;
    logic [`SSSP_DATA_W-1:0] wdat;
    logic [`SSSP_DATA_W-1:0] rdat;

    // The requester still shows valid in the done cycle, so no launch then
    assign launch = (state == PORT_IDLE) && req.valid && !done;

    assign bus_m2s = '{
        cyc: (state == PORT_CYCLE),
        stb: (state == PORT_CYCLE),
        we:  we,
        adr: adr,
        dat: wdat
    };
    assign rsp = '{done: done, data: rdat};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= PORT_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (launch) begin
                        state <= PORT_CYCLE;
                    end
                end
                PORT_CYCLE: begin
                    if (bus_s2m.ack) begin
                        state <= PORT_IDLE;
                        done  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Address and data stay fixed for the whole bus cycle
    always_ff @(posedge clk) begin
        if (launch) begin
            we   <= req.write;
            adr  <= req.addr;
            wdat <= req.data;
        end
        if (state == PORT_CYCLE && bus_s2m.ack) begin
            rdat <= bus_s2m.dat;
        end
    end

endmodule

// File: wb_pkg.sv
`include "sssp_macros.svh"

package wb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone classic, master to slave and slave to master
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`SSSP_ADDR_W-1:0] adr;
        logic [`SSSP_DATA_W-1:0] dat;
    } wb_m2s_t;

    typedef struct packed {
        logic                    ack;
        logic [`SSSP_DATA_W-1:0] dat;
    } wb_s2m_t;

    ////////////////////////////////////////////////////////////////////////////
    // Single-word request between the sequencer and the master port
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`SSSP_ADDR_W-1:0] addr;
        logic [`SSSP_DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                    done;
        logic [`SSSP_DATA_W-1:0] data;
    } mem_rsp_t;

endpackage
